/* cmc_defs.svh */
// Cache RAM controller geometry
// Way, set and line sizes, word width and directory entry layout.
// A directory entry is {valid, dirty, tag} with the tag in the low bits.

`default_nettype none

`ifndef CMC_DEFS_SVH
`define CMC_DEFS_SVH

`define CMC_WAYS 4
`define CMC_SETS 16
`define CMC_WORDS 4
`define CMC_WORD_W 32
`define CMC_TAG_W 8

// Flag positions above the tag field
`define CMC_DIR_VALID_BIT 9
`define CMC_DIR_DIRTY_BIT 8
`define CMC_DIR_W (`CMC_TAG_W + 2)

`endif

`default_nettype wire

/* cmc_pkg.sv */
// Cache RAM controller types
// Vector types for sets, tags, ways, data and directory entries,
// plus the state encoding of the directory init sweep.

`include "cmc_defs.svh"

`default_nettype none

package cmc_pkg;

    typedef logic [$clog2(`CMC_SETS)-1:0] set_t;
    typedef logic [`CMC_TAG_W-1:0] tag_t;
    typedef logic [`CMC_WAYS-1:0] way_vec_t;
    typedef logic [$clog2(`CMC_WORDS)-1:0] word_idx_t;

    typedef logic [`CMC_WORD_W-1:0] data_word_t;
    typedef logic [`CMC_WORD_W/8-1:0] byte_en_t;

    typedef logic [`CMC_DIR_W-1:0] dir_entry_t;

    // Set and word offset side by side
    typedef logic [$clog2(`CMC_SETS*`CMC_WORDS)-1:0] data_addr_t;

    typedef enum logic {
        INIT_SWEEP,
        INIT_DONE
    } init_state_e;

endpackage

`default_nettype wire

/* cmc_sram_1rw.sv */
// Single-port directory RAM
// Full-entry writes, registered one-cycle reads.
// The read register holds its value until the next read.

`default_nettype none

module cmc_sram_1rw #(
    parameter int DEPTH  = 16,
    parameter int DATA_W = 10
) (
    input  logic                clk_i,
    input  logic                cs_i,
    input  logic                we_i,
    input  cmc_pkg::set_t       addr_i,
    input  cmc_pkg::dir_entry_t wdata_i,
    output cmc_pkg::dir_entry_t rdata_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* cmc_sram_be.sv */
// Single-port data RAM with byte enables
// Writes touch only the enabled bytes of the addressed word,
// reads register the whole word one cycle later.

`default_nettype none

module cmc_sram_be #(
    parameter int DEPTH  = 64,
    parameter int DATA_W = 32
) (
    input  logic                clk_i,
    input  logic                cs_i,
    input  logic                we_i,
    input  cmc_pkg::byte_en_t   be_i,
    input  cmc_pkg::data_addr_t addr_i,
    input  cmc_pkg::data_word_t wdata_i,
    output cmc_pkg::data_word_t rdata_o
);

    logic [DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                // Byte lane merge
                for (int b = 0; b < DATA_W/8; b++) begin
                    if (be_i[b]) begin
                        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

/* cmc_dir_ctrl.sv */
// Cache directory controller
// Sweeps all sets clean after reset, then serves tag matches and
// entry updates on one directory RAM per way. The match result
// (hit way and dirty bit) appears the cycle after the match.

`include "cmc_defs.svh"

`default_nettype none

module cmc_dir_ctrl (
    input  logic              clk_i,
    input  logic              rst_ni,
    output logic              ready_o,

    input  logic              dir_match_i,
    input  cmc_pkg::set_t     dir_match_set_i,
    input  cmc_pkg::tag_t     dir_match_tag_i,

    input  logic              dir_updt_i,
    input  cmc_pkg::set_t     dir_updt_set_i,
    input  cmc_pkg::way_vec_t dir_updt_way_i,
    input  logic              dir_updt_valid_i,
    input  logic              dir_updt_dirty_i,
    input  cmc_pkg::tag_t     dir_updt_tag_i,

    output cmc_pkg::way_vec_t dir_hit_way_o,
    output logic              dir_hit_dirty_o
);

    cmc_pkg::init_state_e state_q, state_d;
    cmc_pkg::set_t        init_set_q, init_set_d;

    cmc_pkg::set_t        dir_addr;
    cmc_pkg::way_vec_t    dir_cs;
    cmc_pkg::way_vec_t    dir_we;
    cmc_pkg::dir_entry_t  dir_wentry;
    cmc_pkg::dir_entry_t  dir_rentry [`CMC_WAYS];
    cmc_pkg::way_vec_t    dir_valid;
    cmc_pkg::way_vec_t    dir_dirty;
    cmc_pkg::tag_t        match_tag_q;

    // Init sweep, one set per cycle
    always_comb begin
        state_d    = state_q;
        init_set_d = init_set_q;
        if (state_q == cmc_pkg::INIT_SWEEP) begin
            init_set_d = cmc_pkg::set_t'(init_set_q + 1'b1);
            if (init_set_q == cmc_pkg::set_t'(`CMC_SETS - 1)) begin
                state_d = cmc_pkg::INIT_DONE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= cmc_pkg::INIT_SWEEP;
            init_set_q <= '0;
        end else begin
            state_q    <= state_d;
            init_set_q <= init_set_d;
        end
    end

    assign ready_o = (state_q == cmc_pkg::INIT_DONE);

    // Request mux: sweep first, then match, then update
    always_comb begin
        dir_addr   = '0;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        if (state_q == cmc_pkg::INIT_SWEEP) begin
            dir_addr = init_set_q;
            dir_cs   = '1;
            dir_we   = '1;
        end else if (dir_match_i) begin
            dir_addr = dir_match_set_i;
            dir_cs   = '1;
        end else if (dir_updt_i) begin
            dir_addr = dir_updt_set_i;
            dir_cs   = dir_updt_way_i;
            dir_we   = dir_updt_way_i;
            dir_wentry[`CMC_DIR_VALID_BIT] = dir_updt_valid_i;
            dir_wentry[`CMC_DIR_DIRTY_BIT] = dir_updt_dirty_i;
            dir_wentry[`CMC_TAG_W-1:0]     = dir_updt_tag_i;
        end
    end

    // Compare in the next cycle against the RAM output of this match
    always_ff @(posedge clk_i) begin
        if (ready_o && dir_match_i) begin
            match_tag_q <= dir_match_tag_i;
        end
    end

    for (genvar w = 0; w < `CMC_WAYS; w++) begin : gen_way
        cmc_sram_1rw #(
            .DEPTH  (`CMC_SETS),
            .DATA_W (`CMC_DIR_W)
        ) u_dir_ram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .rdata_o (dir_rentry[w])
        );

        assign dir_valid[w] = dir_rentry[w][`CMC_DIR_VALID_BIT];
        assign dir_dirty[w] = dir_rentry[w][`CMC_DIR_DIRTY_BIT];

        // Invalid lines never hit
        assign dir_hit_way_o[w] = dir_valid[w] &&
                                  (dir_rentry[w][`CMC_TAG_W-1:0] == match_tag_q);
    end

    assign dir_hit_dirty_o = |(dir_hit_way_o & dir_dirty);

    a_dir_access_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_match_i, dir_updt_i}))
        else $error("cmc_dir_ctrl: match and update in the same cycle");

    // Updates never leave a dirty line that is not valid
    a_dirty_implies_valid: assert property (@(posedge clk_i) disable iff (!rst_ni || !ready_o)
        dir_match_i |=> ((dir_dirty & dir_valid) == dir_dirty))
        else $error("cmc_dir_ctrl: directory entry dirty but not valid");

endmodule

`default_nettype wire

/* cmc_data_ctrl.sv */
// Cache data array controller
// Muxes line refills and byte-enabled request writes onto one data
// RAM per way, and returns the read word of the hit way one cycle
// after the read.

`include "cmc_defs.svh"

`default_nettype none

module cmc_data_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                ready_i,
    input  cmc_pkg::way_vec_t   dir_hit_way_i,

    input  logic                data_read_i,
    input  cmc_pkg::set_t       data_read_set_i,
    input  cmc_pkg::word_idx_t  data_read_word_i,
    output cmc_pkg::data_word_t data_read_data_o,

    input  logic                data_write_i,
    input  cmc_pkg::set_t       data_write_set_i,
    input  cmc_pkg::word_idx_t  data_write_word_i,
    input  cmc_pkg::data_word_t data_write_data_i,
    input  cmc_pkg::byte_en_t   data_write_be_i,

    input  logic                data_refill_i,
    input  cmc_pkg::set_t       data_refill_set_i,
    input  cmc_pkg::way_vec_t   data_refill_way_i,
    input  cmc_pkg::word_idx_t  data_refill_word_i,
    input  cmc_pkg::data_word_t data_refill_data_i
);

    logic                read_en;
    cmc_pkg::set_t       wr_set;
    cmc_pkg::word_idx_t  wr_word;
    cmc_pkg::data_word_t wr_data;
    cmc_pkg::byte_en_t   wr_be;
    cmc_pkg::way_vec_t   wr_way;

    cmc_pkg::data_addr_t ram_addr;
    cmc_pkg::way_vec_t   ram_cs;
    cmc_pkg::way_vec_t   ram_we;
    cmc_pkg::data_word_t ram_rdata [`CMC_WAYS];

    // Lines are laid out word by word within a set
    function automatic cmc_pkg::data_addr_t line_addr(input cmc_pkg::set_t set,
                                                      input cmc_pkg::word_idx_t word);
        return {set, word};
    endfunction

    assign read_en = ready_i && data_read_i;

    // Refill wins over request write
    always_comb begin
        wr_set  = data_write_set_i;
        wr_word = data_write_word_i;
        wr_data = data_write_data_i;
        wr_be   = data_write_be_i;
        wr_way  = '0;
        if (ready_i && data_refill_i) begin
            wr_set  = data_refill_set_i;
            wr_word = data_refill_word_i;
            wr_data = data_refill_data_i;
            wr_be   = '1;
            wr_way  = data_refill_way_i;
        end else if (ready_i && data_write_i) begin
            // Way found by the previous match
            wr_way = dir_hit_way_i;
        end
    end

    // Reads enable every way, writes only the targeted one
    always_comb begin
        if (read_en) begin
            ram_addr = line_addr(data_read_set_i, data_read_word_i);
            ram_cs   = '1;
            ram_we   = '0;
        end else begin
            ram_addr = line_addr(wr_set, wr_word);
            ram_cs   = wr_way;
            ram_we   = wr_way;
        end
    end

    for (genvar w = 0; w < `CMC_WAYS; w++) begin : gen_way
        cmc_sram_be #(
            .DEPTH  (`CMC_SETS * `CMC_WORDS),
            .DATA_W (`CMC_WORD_W)
        ) u_data_ram (
            .clk_i   (clk_i),
            .cs_i    (ram_cs[w]),
            .we_i    (ram_we[w]),
            .be_i    (wr_be),
            .addr_i  (ram_addr),
            .wdata_i (wr_data),
            .rdata_o (ram_rdata[w])
        );
    end

    // One-hot read mux, zero on a miss
    always_comb begin
        data_read_data_o = '0;
        for (int w = 0; w < `CMC_WAYS; w++) begin
            if (dir_hit_way_i[w]) begin
                data_read_data_o = data_read_data_o | ram_rdata[w];
            end
        end
    end

    a_data_access_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_i, data_write_i, data_refill_i}))
        else $error("cmc_data_ctrl: more than one data access in a cycle");

    a_refill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_refill_i |-> $onehot0(data_refill_way_i))
        else $error("cmc_data_ctrl: refill way not one-hot");

    // Checked where the directory result steers a write or a read word
    a_hit_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (ready_i && (data_write_i || $past(data_read_i))) |-> $onehot0(dir_hit_way_i))
        else $error("cmc_data_ctrl: hit way not one-hot");

endmodule

`default_nettype wire

/* cmc_memctrl.sv */
// Cache RAM controller top level
// Directory controller and data array controller side by side.
// The directory hit way and ready flag steer the data side.

`default_nettype none

module cmc_memctrl (
    input  logic                clk_i,
    input  logic                rst_ni,
    output logic                ready_o,

    input  logic                dir_match_i,
    input  cmc_pkg::set_t       dir_match_set_i,
    input  cmc_pkg::tag_t       dir_match_tag_i,
    input  logic                dir_updt_i,
    input  cmc_pkg::set_t       dir_updt_set_i,
    input  cmc_pkg::way_vec_t   dir_updt_way_i,
    input  logic                dir_updt_valid_i,
    input  logic                dir_updt_dirty_i,
    input  cmc_pkg::tag_t       dir_updt_tag_i,
    output cmc_pkg::way_vec_t   dir_hit_way_o,
    output logic                dir_hit_dirty_o,

    input  logic                data_read_i,
    input  cmc_pkg::set_t       data_read_set_i,
    input  cmc_pkg::word_idx_t  data_read_word_i,
    output cmc_pkg::data_word_t data_read_data_o,

    input  logic                data_write_i,
    input  cmc_pkg::set_t       data_write_set_i,
    input  cmc_pkg::word_idx_t  data_write_word_i,
    input  cmc_pkg::data_word_t data_write_data_i,
    input  cmc_pkg::byte_en_t   data_write_be_i,

    input  logic                data_refill_i,
    input  cmc_pkg::set_t       data_refill_set_i,
    input  cmc_pkg::way_vec_t   data_refill_way_i,
    input  cmc_pkg::word_idx_t  data_refill_word_i,
    input  cmc_pkg::data_word_t data_refill_data_i
);

    cmc_dir_ctrl u_dir_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .ready_o          (ready_o),
        .dir_match_i      (dir_match_i),
        .dir_match_set_i  (dir_match_set_i),
        .dir_match_tag_i  (dir_match_tag_i),
        .dir_updt_i       (dir_updt_i),
        .dir_updt_set_i   (dir_updt_set_i),
        .dir_updt_way_i   (dir_updt_way_i),
        .dir_updt_valid_i (dir_updt_valid_i),
        .dir_updt_dirty_i (dir_updt_dirty_i),
        .dir_updt_tag_i   (dir_updt_tag_i),
        .dir_hit_way_o    (dir_hit_way_o),
        .dir_hit_dirty_o  (dir_hit_dirty_o)
    );

    cmc_data_ctrl u_data_ctrl (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .ready_i            (ready_o),
        .dir_hit_way_i      (dir_hit_way_o),
        .data_read_i        (data_read_i),
        .data_read_set_i    (data_read_set_i),
        .data_read_word_i   (data_read_word_i),
        .data_read_data_o   (data_read_data_o),
        .data_write_i       (data_write_i),
        .data_write_set_i   (data_write_set_i),
        .data_write_word_i  (data_write_word_i),
        .data_write_data_i  (data_write_data_i),
        .data_write_be_i    (data_write_be_i),
        .data_refill_i      (data_refill_i),
        .data_refill_set_i  (data_refill_set_i),
        .data_refill_way_i  (data_refill_way_i),
        .data_refill_word_i (data_refill_word_i),
        .data_refill_data_i (data_refill_data_i)
    );

endmodule

`default_nettype wire

/* tb_cmc_clkgen.sv */
// Testbench clock and reset source
// 4 ns clock, active-low reset held for 16 cycles

`default_nettype none

module tb_cmc_clkgen (
    output logic clk_o,
    output logic rst_no
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

/* tb_cmc_memctrl.sv */
// Cache RAM controller testbench
// Checks the init sweep, then applies a table of directory and data
// steps whose expected results come from a small array model.

`include "cmc_defs.svh"

`default_nettype none

module tb_cmc_memctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [1:0] OP_UPDT   = 2'd0;
    localparam logic [1:0] OP_MREAD  = 2'd1;
    localparam logic [1:0] OP_REFILL = 2'd2;
    localparam logic [1:0] OP_MWRITE = 2'd3;
    localparam int MAX_STEPS = 64;

    logic clk, rst_n, ready_o;
    logic dir_match_i, dir_updt_i, dir_updt_valid_i, dir_updt_dirty_i, dir_hit_dirty_o;
    logic data_read_i, data_write_i, data_refill_i;
    cmc_pkg::set_t       dir_match_set_i, dir_updt_set_i;
    cmc_pkg::set_t       data_read_set_i, data_write_set_i, data_refill_set_i;
    cmc_pkg::tag_t       dir_match_tag_i, dir_updt_tag_i;
    cmc_pkg::way_vec_t   dir_updt_way_i, dir_hit_way_o, data_refill_way_i;
    cmc_pkg::word_idx_t  data_read_word_i, data_write_word_i, data_refill_word_i;
    cmc_pkg::data_word_t data_read_data_o, data_write_data_i, data_refill_data_i;
    cmc_pkg::byte_en_t   data_write_be_i;

    // Step table
    string               step_name  [MAX_STEPS];
    logic [1:0]          step_op    [MAX_STEPS];
    cmc_pkg::set_t       step_set   [MAX_STEPS];
    cmc_pkg::tag_t       step_tag   [MAX_STEPS];
    cmc_pkg::way_vec_t   step_way   [MAX_STEPS];
    cmc_pkg::word_idx_t  step_word  [MAX_STEPS];
    cmc_pkg::data_word_t step_data  [MAX_STEPS];
    cmc_pkg::byte_en_t   step_be    [MAX_STEPS];
    logic                step_dirty [MAX_STEPS];
    cmc_pkg::way_vec_t   exp_hit    [MAX_STEPS];
    logic                exp_dirty  [MAX_STEPS];
    cmc_pkg::data_word_t exp_data   [MAX_STEPS];
    int n_steps = 0;

    // Array model, all lines invalid after the sweep
    logic                m_valid [`CMC_SETS][`CMC_WAYS];
    logic                m_dirty [`CMC_SETS][`CMC_WAYS];
    cmc_pkg::tag_t       m_tag   [`CMC_SETS][`CMC_WAYS];
    cmc_pkg::data_word_t m_data  [`CMC_SETS][`CMC_WORDS][`CMC_WAYS];

    int checks = 0;
    int value_errors = 0;
    int ready_errors = 0;
    int cycle_cnt = 0;
    int cycle_limit = 1000;
    logic [31:0] rng = 32'hf2bfa9da;

    tb_cmc_clkgen u_clkgen (.clk_o(clk), .rst_no(rst_n));

    cmc_memctrl uut (
        .clk_i(clk), .rst_ni(rst_n), .ready_o(ready_o),
        .dir_match_i(dir_match_i), .dir_match_set_i(dir_match_set_i),
        .dir_match_tag_i(dir_match_tag_i), .dir_updt_i(dir_updt_i),
        .dir_updt_set_i(dir_updt_set_i), .dir_updt_way_i(dir_updt_way_i),
        .dir_updt_valid_i(dir_updt_valid_i), .dir_updt_dirty_i(dir_updt_dirty_i),
        .dir_updt_tag_i(dir_updt_tag_i), .dir_hit_way_o(dir_hit_way_o),
        .dir_hit_dirty_o(dir_hit_dirty_o), .data_read_i(data_read_i),
        .data_read_set_i(data_read_set_i), .data_read_word_i(data_read_word_i),
        .data_read_data_o(data_read_data_o), .data_write_i(data_write_i),
        .data_write_set_i(data_write_set_i), .data_write_word_i(data_write_word_i),
        .data_write_data_i(data_write_data_i), .data_write_be_i(data_write_be_i),
        .data_refill_i(data_refill_i), .data_refill_set_i(data_refill_set_i),
        .data_refill_way_i(data_refill_way_i), .data_refill_word_i(data_refill_word_i),
        .data_refill_data_i(data_refill_data_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cmc_pkg::data_word_t next_word();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Valid lines whose stored tag equals the lookup tag
    function automatic cmc_pkg::way_vec_t model_match(input cmc_pkg::set_t s,
                                                      input cmc_pkg::tag_t t);
        cmc_pkg::way_vec_t hit;
        hit = '0;
        for (int w = 0; w < `CMC_WAYS; w++) begin
            hit[w] = m_valid[s][w] && (m_tag[s][w] == t);
        end
        return hit;
    endfunction

    task automatic add_step(input string name, input logic [1:0] op, input cmc_pkg::set_t s,
                            input cmc_pkg::tag_t t, input int way, input cmc_pkg::word_idx_t k,
                            input cmc_pkg::data_word_t d, input cmc_pkg::byte_en_t be,
                            input logic dirty);
        cmc_pkg::way_vec_t hit;
        int i;
        i = n_steps;
        hit = model_match(s, t);
        step_name[i] = name;
        step_op[i] = op;
        step_set[i] = s;
        step_tag[i] = t;
        step_way[i] = cmc_pkg::way_vec_t'(1 << way);
        step_word[i] = k;
        step_data[i] = d;
        step_be[i] = be;
        step_dirty[i] = dirty;
        exp_hit[i] = hit;
        exp_dirty[i] = 1'b0;
        exp_data[i] = '0;
        for (int w = 0; w < `CMC_WAYS; w++) begin
            if (hit[w]) begin
                exp_dirty[i] = exp_dirty[i] | m_dirty[s][w];
                if (op == OP_MREAD) exp_data[i] = m_data[s][k][w];
                // Request write merges the enabled bytes into the hit way
                if (op == OP_MWRITE) begin
                    for (int b = 0; b < `CMC_WORD_W/8; b++) begin
                        if (be[b]) m_data[s][k][w][8*b +: 8] = d[8*b +: 8];
                    end
                end
            end
        end
        if (op == OP_UPDT) begin
            m_valid[s][way] = 1'b1;
            m_dirty[s][way] = dirty;
            m_tag[s][way] = t;
        end
        if (op == OP_REFILL) m_data[s][k][way] = d;
        n_steps++;
    endtask

    task automatic build_table();
        cmc_pkg::tag_t t;
        // Tag zero equals the cleared tag field, so only the valid bit keeps these a miss
        for (int s = 0; s < `CMC_SETS; s++) begin
            add_step("sweep_miss", OP_MREAD, cmc_pkg::set_t'(s), 8'h00,
                     0, 2'd0, '0, '0, 1'b0);
        end
        add_step("refill", OP_REFILL, 4'd3, 8'h00, 1, 2'd1, next_word(), '1, 1'b0);
        add_step("update", OP_UPDT, 4'd3, 8'h5a, 1, 2'd0, '0, '0, 1'b1);
        add_step("update_hit", OP_MREAD, 4'd3, 8'h5a, 0, 2'd1, '0, '0, 1'b0);
        add_step("tag_miss", OP_MREAD, 4'd3, 8'h5b, 0, 2'd1, '0, '0, 1'b0);
        add_step("refill", OP_REFILL, 4'd5, 8'h00, 2, 2'd0, next_word(), '1, 1'b0);
        add_step("update", OP_UPDT, 4'd5, 8'hc3, 2, 2'd0, '0, '0, 1'b0);
        add_step("update_hit", OP_MREAD, 4'd5, 8'hc3, 0, 2'd0, '0, '0, 1'b0);
        add_step("merge_write", OP_MWRITE, 4'd3, 8'h5a, 0, 2'd1, next_word(), 4'b0101, 1'b0);
        add_step("merge_read", OP_MREAD, 4'd3, 8'h5a, 0, 2'd1, '0, '0, 1'b0);
        add_step("merge_write", OP_MWRITE, 4'd3, 8'h5a, 0, 2'd1, next_word(), 4'b1000, 1'b0);
        add_step("merge_read", OP_MREAD, 4'd3, 8'h5a, 0, 2'd1, '0, '0, 1'b0);
        // One word of set 9 in all four ways, distinct tags
        t = cmc_pkg::tag_t'(next_word());
        for (int w = 0; w < `CMC_WAYS; w++) begin
            add_step("refill", OP_REFILL, 4'd9, 8'h00, w, 2'd2, next_word(), '1, 1'b0);
            add_step("update", OP_UPDT, 4'd9, cmc_pkg::tag_t'(t + w), w, 2'd0, '0, '0, w[0]);
        end
        for (int w = 0; w < `CMC_WAYS; w++) begin
            add_step("way_select", OP_MREAD, 4'd9, cmc_pkg::tag_t'(t + w), 0, 2'd2, '0, '0, 1'b0);
        end
        add_step("way_miss", OP_MREAD, 4'd9, cmc_pkg::tag_t'(t + 4), 0, 2'd2, '0, '0, 1'b0);
        add_step("miss_write", OP_MWRITE, 4'd9, cmc_pkg::tag_t'(t + 4), 0, 2'd2, next_word(),
                 '1, 1'b0);
        add_step("way_select", OP_MREAD, 4'd9, t, 0, 2'd2, '0, '0, 1'b0);
    endtask

    task automatic check_value(input string name, input int i, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            value_errors++;
            $display("Error %s (step %0d, %s): expected %h, actual %h", name, i, what, exp, act);
        end
    endtask

    task automatic check_result(input int i, input logic with_data);
        assert (ready_o === 1'b1) else begin
            ready_errors++;
            $display("ready_o is not high after the init sweep (step %0d)", i);
        end
        check_value(step_name[i], i, "hit way", 32'(exp_hit[i]), 32'(dir_hit_way_o));
        check_value(step_name[i], i, "dirty", 32'(exp_dirty[i]), 32'(dir_hit_dirty_o));
        if (with_data) begin
            check_value(step_name[i], i, "read data", exp_data[i], data_read_data_o);
        end
    endtask

    task automatic run_step(input int i);
        @(posedge clk);
        case (step_op[i])
            OP_UPDT: begin
                dir_updt_i <= 1'b1;
                dir_updt_set_i <= step_set[i];
                dir_updt_way_i <= step_way[i];
                dir_updt_dirty_i <= step_dirty[i];
                dir_updt_tag_i <= step_tag[i];
                @(posedge clk);
                dir_updt_i <= 1'b0;
            end
            OP_REFILL: begin
                data_refill_i <= 1'b1;
                data_refill_set_i <= step_set[i];
                data_refill_way_i <= step_way[i];
                data_refill_word_i <= step_word[i];
                data_refill_data_i <= step_data[i];
                @(posedge clk);
                data_refill_i <= 1'b0;
            end
            default: begin
                dir_match_i <= 1'b1;
                dir_match_set_i <= step_set[i];
                dir_match_tag_i <= step_tag[i];
                if (step_op[i] == OP_MREAD) begin
                    data_read_i <= 1'b1;
                    data_read_set_i <= step_set[i];
                    data_read_word_i <= step_word[i];
                end
                @(posedge clk);
                dir_match_i <= 1'b0;
                data_read_i <= 1'b0;
                if (step_op[i] == OP_MWRITE) begin
                    data_write_i <= 1'b1;
                    data_write_set_i <= step_set[i];
                    data_write_word_i <= step_word[i];
                    data_write_data_i <= step_data[i];
                    data_write_be_i <= step_be[i];
                end
                @(negedge clk);
                check_result(i, step_op[i] == OP_MREAD);
                if (step_op[i] == OP_MWRITE) begin
                    @(posedge clk);
                    data_write_i <= 1'b0;
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: test sequence still running after %0d cycles", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int ready_cycles;
        {dir_match_i, dir_updt_i, data_read_i, data_write_i, data_refill_i} = '0;
        dir_updt_valid_i = 1'b1;
        dir_updt_dirty_i = 1'b0;
        {dir_match_set_i, dir_updt_set_i, data_read_set_i} = '0;
        {data_write_set_i, data_refill_set_i} = '0;
        {dir_match_tag_i, dir_updt_tag_i, dir_updt_way_i, data_refill_way_i} = '0;
        {data_read_word_i, data_write_word_i, data_refill_word_i} = '0;
        {data_write_data_i, data_refill_data_i, data_write_be_i} = '0;
        for (int s = 0; s < `CMC_SETS; s++) begin
            for (int w = 0; w < `CMC_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w] = '0;
                for (int k = 0; k < `CMC_WORDS; k++) m_data[s][k][w] = '0;
            end
        end
        build_table();
        cycle_limit = 16 + `CMC_SETS + 4 * n_steps + 50;

        @(negedge clk);
        while (rst_n !== 1'b1) begin
            assert (ready_o === 1'b0) else begin
                ready_errors++;
                $display("ready_o is high while reset is asserted");
            end
            @(negedge clk);
        end
        // One set swept per cycle after release
        ready_cycles = 0;
        while (ready_o !== 1'b1 && ready_cycles < 2 * `CMC_SETS) begin
            @(negedge clk);
            ready_cycles++;
        end
        assert (ready_cycles == `CMC_SETS) else begin
            ready_errors++;
            $display("ready_o rose %0d cycles after reset release, not %0d", ready_cycles,
                     `CMC_SETS);
        end

        for (int i = 0; i < n_steps; i++) run_step(i);
        repeat (2) @(posedge clk);

        $display("Checks: %0d, value errors: %0d, ready errors: %0d", checks, value_errors,
                 ready_errors);
        if (value_errors + ready_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
cmc_pkg.sv
cmc_sram_1rw.sv
cmc_sram_be.sv
cmc_dir_ctrl.sv
cmc_data_ctrl.sv
cmc_memctrl.sv
tb_cmc_clkgen.sv
tb_cmc_memctrl.sv
